//--- build.f
hw/dc_pkg.sv
hw/dc_timing_if.sv
hw/dc_ctrl_regs.sv
hw/dc_timing_gen.sv
hw/dc_line_buffer.sv
hw/dc_pixel_fmt.sv
hw/display_controller.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/dc_props.sv
dv/tb_top.sv

//--- dv/dc_props.sv
`timescale 1ns/1ps

module dc_props (
  input logic        pxl_clk_i,
  input logic        rst_ni,
  input logic        display_active_i,
  input logic        end_of_frame_i,
  input logic        pixel_valid_i,
  input logic [15:0] h_counter_i,
  input logic [15:0] v_counter_i,
  input logic [15:0] h_total_i,
  input logic [15:0] v_total_i
);

  int fail_count = 0;

  eof_single_cycle: assert property (@(posedge pxl_clk_i) disable iff (!rst_ni)
    end_of_frame_i |=> !end_of_frame_i)
    else begin
      $error("end_of_frame held for more than one cycle");
      fail_count++;
    end

  // A stopped display shows no pixels and keeps its counters at zero
  idle_when_disabled: assert property (@(posedge pxl_clk_i) disable iff (!rst_ni)
    !display_active_i |-> !pixel_valid_i && h_counter_i == '0 && v_counter_i == '0)
    else begin
      $error("display off but pixels or counters still running");
      fail_count++;
    end

  counters_in_range: assert property (@(posedge pxl_clk_i) disable iff (!rst_ni)
    h_counter_i < h_total_i && v_counter_i < v_total_i)
    else begin
      $error("counter reached its total");
      fail_count++;
    end

endmodule

//--- dv/dc_vectors.txt
# W addr data | R addr expected | L lb_addr data | I cycles | E frames | D test
# F pixels hsync vsync polarity | P x y bgr | Q x y r5g6b5 (all hex except I E D P Q x y)
R 00 0
R 08 3
R 20 320
R 24 280
R 30 20D
R 50 280
R 54 1E0
R 58 0
R 60 FFFFFF
W 00 1
W 20 C
I 2
R 00 1
R 20 320
W 00 0
I 4
R 00 0
W 20 C
R 20 C
D 1
W 24 8
W 28 9
W 2C B
W 30 8
W 34 6
W 38 6
W 3C 8
W 08 3
W 50 8
W 54 6
W 40 1
W 00 1
E 2
F 30 10 18 3
W 00 0
I 4
W 08 0
W 00 1
E 1
F 30 10 18 0
D 2
W 50 6
W 54 4
W 60 123456
W 40 1
E 2
R 50 6
R 40 0
L 00 00AABBCC
L 13 00112233
L 05 00C0FFEE
L 07 00777777
E 1
P 0 0 AABBCC
P 3 1 112233
P 5 2 C0FFEE
P 3 3 112233
P 7 0 123456
P 2 5 123456
D 3
W 50 8
W 60 FF
E 2
P 7 0 123456
R 50 6
R 60 123456
W 40 1
E 2
R 40 0
R 50 8
R 60 FF
P 7 0 777777
P 3 5 0000FF
D 5
L 01 F80007E0
L 12 1234ABCD
W 58 1
W 40 1
E 2
R 58 1
Q 2 0 07E0
Q 3 0 F800
Q 4 1 ABCD
Q 5 1 1234
D 4

//--- dv/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input  logic        pxl_clk_i,
  input  logic [31:0] ctrl_rdata_i,
  input  logic [7:0]  red_i,
  input  logic [7:0]  green_i,
  input  logic [7:0]  blue_i,
  input  logic        pixel_i,
  input  logic        hsync_i,
  input  logic        vsync_i,
  input  logic        end_of_frame_i,
  input  int          req_id_i,
  input  int          kind_i,
  input  logic [31:0] arg_a_i,
  input  logic [31:0] arg_b_i,
  input  logic [31:0] arg_c_i,
  input  logic [31:0] arg_d_i,
  output int          served_id_o,
  output int          error_count_o
);

  localparam int Timeout = 600;

  int   served_id = 0;
  int   errors = 0;
  int   test_errors = 0;
  int   tests_run = 0;
  int   tests_bad = 0;
  int   wait_cnt = 0;
  int   x = 0;
  int   y = 0;
  int   pix_cnt, hs_cnt, vs_cnt;
  logic counting = 1'b0;
  logic prev_hsync = 1'b0;
  logic prev_pixel = 1'b0;

  assign served_id_o   = served_id;
  assign error_count_o = errors;

  // Each channel widened by repeating its top bits
  function automatic logic [23:0] expand_565(input logic [15:0] c);
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    r = {c[4:0], 3'b000} | {5'b0, c[4:2]};
    g = {c[10:5], 2'b00} | {6'b0, c[10:9]};
    b = {c[15:11], 3'b000} | {5'b0, c[15:13]};
    return {b, g, r};
  endfunction

  task automatic mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
    $display("** Error at %0t ns: %s = %h, expected %h", $time, sig, got, exp);
    errors++;
    test_errors++;
  endtask

  task automatic complete();
    served_id = req_id_i;
    wait_cnt  = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // Sampled on the falling edge, away from DUT updates
  ////////////////////////////////////////////////////////////

  always @(negedge pxl_clk_i) begin
    logic [23:0] rgb;
    logic [23:0] exp_rgb;
    rgb = {blue_i, green_i, red_i};
    if (hsync_i != prev_hsync) x = 0;
    if (pixel_i && !prev_pixel) y++;
    if (end_of_frame_i) y = -1;

    if (served_id != req_id_i) begin
      case (kind_i)
        1: begin
          if (ctrl_rdata_i !== arg_b_i) mismatch("ctrl_rdata_o", ctrl_rdata_i, arg_b_i);
          complete();
        end
        2, 3: begin
          exp_rgb = (kind_i == 3) ? expand_565(arg_c_i[15:0]) : arg_c_i[23:0];
          if (pixel_i && x == int'(arg_a_i) && y == int'(arg_b_i)) begin
            if (rgb !== exp_rgb) mismatch("{blue_o,green_o,red_o}", 32'(rgb), 32'(exp_rgb));
            complete();
          end else if (wait_cnt >= Timeout) begin
            $display("Pixel (%0d,%0d) was never shown", arg_a_i, arg_b_i);
            errors++;
            test_errors++;
            complete();
          end else begin
            wait_cnt++;
          end
        end
        4: begin
          if (counting && end_of_frame_i) begin
            counting = 1'b0;
            if (pix_cnt != int'(arg_a_i)) mismatch("pixel_o count", 32'(pix_cnt), arg_a_i);
            if (hs_cnt != int'(arg_b_i)) mismatch("hsync_o active count", 32'(hs_cnt), arg_b_i);
            if (vs_cnt != int'(arg_c_i)) mismatch("vsync_o active count", 32'(vs_cnt), arg_c_i);
            complete();
          end else if (wait_cnt >= Timeout) begin
            $display("Frame statistics: no complete frame seen");
            errors++;
            test_errors++;
            counting = 1'b0;
            complete();
          end else begin
            wait_cnt++;
            if (end_of_frame_i && !counting) begin
              counting = 1'b1;
              pix_cnt  = 0;
              hs_cnt   = 0;
              vs_cnt   = 0;
            end
            if (counting) begin
              pix_cnt += int'(pixel_i);
              hs_cnt  += int'(hsync_i != arg_d_i[0]);
              vs_cnt  += int'(vsync_i != arg_d_i[1]);
            end
          end
        end
        5: begin
          tests_run++;
          if (test_errors == 0) begin
            $display("test %0d: ok", arg_a_i);
          end else begin
            $display("test %0d: %0d errors", arg_a_i, test_errors);
            tests_bad++;
          end
          test_errors = 0;
          complete();
        end
        default: begin
          $display("summary: %0d tests run, %0d with errors, %0d errors in all",
                   tests_run, tests_bad, errors);
          complete();
        end
      endcase
    end

    if (pixel_i) x++;
    prev_hsync = hsync_i;
    prev_pixel = pixel_i;
  end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int ResetCycles = 8
) (
  output logic pxl_clk_o,
  output logic rst_no
);

  // 40 ns pixel clock
  initial begin
    pxl_clk_o = 1'b0;
    forever #20 pxl_clk_o = ~pxl_clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge pxl_clk_o);
    #2 rst_no = 1'b1;
  end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam int LineWords    = 16;
  localparam int LbAddrWidth  = $clog2(LineWords) + 1;
  localparam int AckTimeout   = 2000;
  localparam int FrameTimeout = 1000;

  logic                   pxl_clk;
  logic                   rst_n;
  logic                   ctrl_en;
  logic                   ctrl_we;
  logic [7:0]             ctrl_addr;
  logic [31:0]            ctrl_wdata;
  logic [31:0]            ctrl_rdata;
  logic                   lb_we;
  logic [LbAddrWidth-1:0] lb_addr;
  logic [31:0]            lb_wdata;
  logic [7:0]             red;
  logic [7:0]             green;
  logic [7:0]             blue;
  logic                   pixel;
  logic                   hsync;
  logic                   vsync;
  logic                   frame_end;

  int          req_id = 0;
  int          kind = 0;
  logic [31:0] arg_a;
  logic [31:0] arg_b;
  logic [31:0] arg_c;
  logic [31:0] arg_d;
  int          served_id;
  int          error_count;
  int          bad_commands = 0;
  logic        run_aborted = 1'b0;
  logic [31:0] lfsr_state = 32'h6a25_6b95;

  tb_clk_gen u_clk_gen (.pxl_clk_o(pxl_clk), .rst_no(rst_n));

  display_controller #(.LineWords(LineWords)) dut_i (
    .pxl_clk_i (pxl_clk), .rst_ni (rst_n),
    .ctrl_en_i (ctrl_en), .ctrl_we_i (ctrl_we), .ctrl_addr_i (ctrl_addr),
    .ctrl_wdata_i (ctrl_wdata), .ctrl_rdata_o (ctrl_rdata),
    .lb_we_i (lb_we), .lb_addr_i (lb_addr), .lb_wdata_i (lb_wdata),
    .red_o (red), .green_o (green), .blue_o (blue),
    .pixel_o (pixel), .hsync_o (hsync), .vsync_o (vsync)
  );

  assign frame_end = dut_i.u_timing_gen.end_of_frame_o;

  tb_checker u_checker (
    .pxl_clk_i (pxl_clk), .ctrl_rdata_i (ctrl_rdata),
    .red_i (red), .green_i (green), .blue_i (blue),
    .pixel_i (pixel), .hsync_i (hsync), .vsync_i (vsync), .end_of_frame_i (frame_end),
    .req_id_i (req_id), .kind_i (kind),
    .arg_a_i (arg_a), .arg_b_i (arg_b), .arg_c_i (arg_c), .arg_d_i (arg_d),
    .served_id_o (served_id), .error_count_o (error_count)
  );

  bind dc_timing_gen dc_props u_props (
    .pxl_clk_i (pxl_clk_i), .rst_ni (rst_ni),
    .display_active_i (display_active_o), .end_of_frame_i (end_of_frame_o),
    .pixel_valid_i (pixel_valid_o),
    .h_counter_i (h_counter), .v_counter_i (v_counter),
    .h_total_i (tim.h_total), .v_total_i (tim.v_total)
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge pxl_clk);
    #2;
    ctrl_en    = 1'b1;
    ctrl_we    = 1'b1;
    ctrl_addr  = addr[7:0];
    ctrl_wdata = data;
    @(posedge pxl_clk);
    #2;
    ctrl_en = 1'b0;
    ctrl_we = 1'b0;
  endtask

  task automatic lb_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge pxl_clk);
    #2;
    lb_we    = 1'b1;
    lb_addr  = addr[LbAddrWidth-1:0];
    lb_wdata = data;
    @(posedge pxl_clk);
    #2;
    lb_we = 1'b0;
  endtask

  // Hands one check to the checker and waits until it is done
  task automatic request_check(input int k, input logic [31:0] a, input logic [31:0] b,
                               input logic [31:0] c, input logic [31:0] d);
    int cnt;
    cnt = 0;
    @(posedge pxl_clk);
    #2;
    kind  = k;
    arg_a = a;
    arg_b = b;
    arg_c = c;
    arg_d = d;
    req_id++;
    while (served_id != req_id) begin
      @(posedge pxl_clk);
      cnt++;
      if (cnt > AckTimeout) begin
        $display("Timeout: checker gave no result for request %0d", req_id);
        run_aborted = 1'b1;
        break;
      end
    end
  endtask

  task automatic reg_read(input logic [31:0] addr, input logic [31:0] exp);
    @(posedge pxl_clk);
    #2;
    ctrl_en   = 1'b1;
    ctrl_addr = addr[7:0];
    @(posedge pxl_clk);
    #2;
    ctrl_en = 1'b0;
    request_check(1, addr, exp, 0, 0);
  endtask

  task automatic wait_frames(input int n);
    int cnt;
    for (int i = 0; i < n; i++) begin
      cnt = 0;
      do begin
        @(negedge pxl_clk);
        cnt++;
        if (cnt > FrameTimeout) begin
          $display("Timeout: no end of frame within %0d cycles", FrameTimeout);
          run_aborted = 1'b1;
          return;
        end
      end while (frame_end !== 1'b1);
    end
  endtask

  task automatic fill_line_buffer();
    logic [31:0] data;
    for (int w = 0; w < 2 * LineWords; w++) begin
      data = '0;
      for (int i = 0; i < 32; i++) data = {data[30:0], lfsr_step()};
      lb_write(32'(w), data);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Vector file interpreter
  ////////////////////////////////////////////////////////////

  initial begin
    string       cmd;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    int          fd;
    int          code;
    int          cnt;
    ctrl_en    = 1'b0;
    ctrl_we    = 1'b0;
    ctrl_addr  = '0;
    ctrl_wdata = '0;
    lb_we      = 1'b0;
    lb_addr    = '0;
    lb_wdata   = '0;
    fd  = 0;
    cnt = 0;
    while (rst_n !== 1'b1) begin
      @(posedge pxl_clk);
      cnt++;
      if (cnt > 100) begin
        $display("Reset was never released");
        run_aborted = 1'b1;
        break;
      end
    end
    if (!run_aborted) begin
      fill_line_buffer();
      fd = $fopen("dv/dc_vectors.txt", "r");
      if (fd == 0) begin
        $display("Could not open dv/dc_vectors.txt");
        run_aborted = 1'b1;
      end
    end
    if (!run_aborted) begin
      while (!run_aborted && !$feof(fd)) begin
        code = $fscanf(fd, "%s", cmd);
        if (code != 1) break;
        case (cmd)
          "#": code = $fgets(line, fd);
          "W": begin
            code = $fscanf(fd, "%h %h", a, b);
            reg_write(a, b);
          end
          "R": begin
            code = $fscanf(fd, "%h %h", a, b);
            reg_read(a, b);
          end
          "L": begin
            code = $fscanf(fd, "%h %h", a, b);
            lb_write(a, b);
          end
          "I": begin
            code = $fscanf(fd, "%d", a);
            repeat (int'(a)) @(posedge pxl_clk);
          end
          "E": begin
            code = $fscanf(fd, "%d", a);
            wait_frames(int'(a));
          end
          "F": begin
            code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
            request_check(4, a, b, c, d);
          end
          "P", "Q": begin
            code = $fscanf(fd, "%d %d %h", a, b, c);
            request_check((cmd == "P") ? 2 : 3, a, b, c, 0);
          end
          "D": begin
            code = $fscanf(fd, "%d", a);
            request_check(5, a, 0, 0, 0);
          end
          default: begin
            $display("Unknown vector command %s", cmd);
            bad_commands++;
          end
        endcase
      end
      $fclose(fd);
    end
    if (!run_aborted) begin
      request_check(6, 0, 0, 0, 0);
    end
    if (!run_aborted && error_count == 0 && bad_commands == 0 &&
        dut_i.u_timing_gen.u_props.fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- hw/dc_ctrl_regs.sv
`timescale 1ns/1ps

module dc_ctrl_regs import dc_pkg::*; (
  input  logic                     pxl_clk_i,
  input  logic                     rst_ni,

  input  logic                     ctrl_en_i,
  input  logic                     ctrl_we_i,
  input  logic [CtrlAddrWidth-1:0] ctrl_addr_i,
  input  logic [31:0]              ctrl_wdata_i,
  output logic [31:0]              ctrl_rdata_o,

  input  logic                     display_active_i,
  input  logic                     end_of_frame_i,
  output logic                     display_en_o,
  output fb_cfg_t                  fb_cfg_o,

  dc_timing_if.regs                tim
);

  dc_reg_e word_idx;
  logic    fb_commit;
  fb_cfg_t fb_pending;
  logic    allow_timing_change;

  assign word_idx = dc_reg_e'(ctrl_addr_i[CtrlAddrWidth-1:2]);

  // Timing only changes with the display fully stopped
  assign allow_timing_change = !display_en_o && !display_active_i;

  ////////////////////////////////////////////////////////////
  // Register writes and commit
  ////////////////////////////////////////////////////////////

  always_ff @(posedge pxl_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      display_en_o   <= 1'b0;
      tim.hsync_pol  <= 1'b1;
      tim.vsync_pol  <= 1'b1;
      tim.h_total    <= HTotalReset;
      tim.h_end_disp <= HEndDispReset;
      tim.h_srt_sync <= HSrtSyncReset;
      tim.h_end_sync <= HEndSyncReset;
      tim.v_total    <= VTotalReset;
      tim.v_end_disp <= VEndDispReset;
      tim.v_srt_sync <= VSrtSyncReset;
      tim.v_end_sync <= VEndSyncReset;
      fb_commit      <= 1'b0;
      fb_pending     <= FbCfgReset;
      fb_cfg_o       <= FbCfgReset;
    end else begin
      // Pending values go live between frames
      if (end_of_frame_i && fb_commit) begin
        fb_cfg_o  <= fb_pending;
        fb_commit <= 1'b0;
      end

      if (ctrl_en_i && ctrl_we_i) begin
        if (allow_timing_change) begin
          case (word_idx)
            reg_polarity: begin
              tim.vsync_pol <= ctrl_wdata_i[1];
              tim.hsync_pol <= ctrl_wdata_i[0];
            end
            reg_h_total:    tim.h_total    <= ctrl_wdata_i[TimingWidth-1:0];
            reg_h_end_disp: tim.h_end_disp <= ctrl_wdata_i[TimingWidth-1:0];
            reg_h_srt_sync: tim.h_srt_sync <= ctrl_wdata_i[TimingWidth-1:0];
            reg_h_end_sync: tim.h_end_sync <= ctrl_wdata_i[TimingWidth-1:0];
            reg_v_total:    tim.v_total    <= ctrl_wdata_i[TimingWidth-1:0];
            reg_v_end_disp: tim.v_end_disp <= ctrl_wdata_i[TimingWidth-1:0];
            reg_v_srt_sync: tim.v_srt_sync <= ctrl_wdata_i[TimingWidth-1:0];
            reg_v_end_sync: tim.v_end_sync <= ctrl_wdata_i[TimingWidth-1:0];
            default: ;
          endcase
        end

        case (word_idx)
          reg_enable:     display_en_o        <= ctrl_wdata_i[0];
          reg_fb_commit:  fb_commit           <= ctrl_wdata_i[0];
          reg_fb_width:   fb_pending.width    <= ctrl_wdata_i[FbDimWidth-1:0];
          reg_fb_height:  fb_pending.height   <= ctrl_wdata_i[FbDimWidth-1:0];
          reg_fb_depth:   fb_pending.depth    <= ctrl_wdata_i[0];
          reg_bg_color:   fb_pending.bg_color <= ctrl_wdata_i[ColorWidth-1:0];
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////

  always_ff @(posedge pxl_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_rdata_o <= '0;
    end else if (ctrl_en_i) begin
      case (word_idx)
        reg_enable:     ctrl_rdata_o <= 32'(display_active_i);
        reg_polarity:   ctrl_rdata_o <= 32'({tim.vsync_pol, tim.hsync_pol});
        reg_h_total:    ctrl_rdata_o <= 32'(tim.h_total);
        reg_h_end_disp: ctrl_rdata_o <= 32'(tim.h_end_disp);
        reg_h_srt_sync: ctrl_rdata_o <= 32'(tim.h_srt_sync);
        reg_h_end_sync: ctrl_rdata_o <= 32'(tim.h_end_sync);
        reg_v_total:    ctrl_rdata_o <= 32'(tim.v_total);
        reg_v_end_disp: ctrl_rdata_o <= 32'(tim.v_end_disp);
        reg_v_srt_sync: ctrl_rdata_o <= 32'(tim.v_srt_sync);
        reg_v_end_sync: ctrl_rdata_o <= 32'(tim.v_end_sync);
        reg_fb_commit:  ctrl_rdata_o <= 32'(fb_commit);
        // Committed values, not the pending ones
        reg_fb_width:   ctrl_rdata_o <= 32'(fb_cfg_o.width);
        reg_fb_height:  ctrl_rdata_o <= 32'(fb_cfg_o.height);
        reg_fb_depth:   ctrl_rdata_o <= 32'(fb_cfg_o.depth);
        reg_bg_color:   ctrl_rdata_o <= 32'(fb_cfg_o.bg_color);
        default:        ctrl_rdata_o <= '0;
      endcase
    end
  end

endmodule

//--- hw/dc_line_buffer.sv
`timescale 1ns/1ps

// Two line halves, the display reads one while the other is refilled
module dc_line_buffer #(
  parameter int LineWords = 1024
) (
  input  logic                       pxl_clk_i,

  input  logic                       we_i,
  input  logic [$clog2(LineWords):0] waddr_i,
  input  logic [31:0]                wdata_i,

  input  logic                       rd_en_i,
  input  logic [$clog2(LineWords):0] rd_addr_i,
  output logic [31:0]                rd_data_o
);

  logic [31:0] mem [2*LineWords];

  always_ff @(posedge pxl_clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Output holds between reads
  always_ff @(posedge pxl_clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

//--- hw/dc_pixel_fmt.sv
`timescale 1ns/1ps

module dc_pixel_fmt import dc_pkg::*; (
  input  logic        pixel_valid_i,
  input  logic        in_fb_i,
  input  logic        half_sel_i,
  input  fb_cfg_t     fb_cfg_i,
  input  logic [31:0] rd_data_i,
  output logic [7:0]  red_o,
  output logic [7:0]  green_o,
  output logic [7:0]  blue_o
);

  // r5g6b5 to b8g8r8, low bits refilled from each channel's top bits
  function automatic logic [ColorWidth-1:0] unpack16(input logic [15:0] c);
    return {c[15:11], c[15:13], c[10:5], c[10:9], c[4:0], c[4:2]};
  endfunction

  logic [ColorWidth-1:0] color;
  logic [15:0]           half_word;

  assign half_word = half_sel_i ? rd_data_i[31:16] : rd_data_i[15:0];

  always_comb begin
    if (!pixel_valid_i) begin
      color = '0;
    end else if (!in_fb_i) begin
      color = fb_cfg_i.bg_color;
    end else if (fb_cfg_i.depth) begin
      color = unpack16(half_word);
    end else begin
      color = rd_data_i[ColorWidth-1:0];
    end
  end

  assign red_o   = color[7:0];
  assign green_o = color[15:8];
  assign blue_o  = color[23:16];

endmodule

//--- hw/dc_pkg.sv
package dc_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int CtrlAddrWidth = 8;
  localparam int TimingWidth   = 16;
  localparam int FbDimWidth    = 12;
  localparam int ColorWidth    = 24;

  // Word index of the register port, taken from address bits 7:2
  typedef enum logic [5:0] {
    reg_enable     = 6'h00,
    reg_polarity   = 6'h02,
    reg_h_total    = 6'h08,
    reg_h_end_disp = 6'h09,
    reg_h_srt_sync = 6'h0A,
    reg_h_end_sync = 6'h0B,
    reg_v_total    = 6'h0C,
    reg_v_end_disp = 6'h0D,
    reg_v_srt_sync = 6'h0E,
    reg_v_end_sync = 6'h0F,
    reg_fb_commit  = 6'h10,
    reg_fb_width   = 6'h14,
    reg_fb_height  = 6'h15,
    reg_fb_depth   = 6'h16,
    reg_bg_color   = 6'h18
  } dc_reg_e;

  // Committed framebuffer configuration
  typedef struct packed {
    logic [FbDimWidth-1:0] width;
    logic [FbDimWidth-1:0] height;
    logic                  depth;
    logic [ColorWidth-1:0] bg_color;
  } fb_cfg_t;

  ////////////////////////////////////////////////////////////
  // Reset defaults, 640x480 VGA
  ////////////////////////////////////////////////////////////

  localparam logic [TimingWidth-1:0] HTotalReset   = 16'd800;
  localparam logic [TimingWidth-1:0] HEndDispReset = 16'd640;
  localparam logic [TimingWidth-1:0] HSrtSyncReset = 16'd656;
  localparam logic [TimingWidth-1:0] HEndSyncReset = 16'd752;
  localparam logic [TimingWidth-1:0] VTotalReset   = 16'd525;
  localparam logic [TimingWidth-1:0] VEndDispReset = 16'd480;
  localparam logic [TimingWidth-1:0] VSrtSyncReset = 16'd490;
  localparam logic [TimingWidth-1:0] VEndSyncReset = 16'd492;

  localparam fb_cfg_t FbCfgReset = '{
    width:    12'd640,
    height:   12'd480,
    depth:    1'b0,
    bg_color: 24'hFFFFFF
  };

endpackage

//--- hw/dc_timing_gen.sv
`timescale 1ns/1ps

module dc_timing_gen import dc_pkg::*; #(
  parameter int LineWords = 1024
) (
  input  logic                         pxl_clk_i,
  input  logic                         rst_ni,
  input  logic                         display_en_i,
  dc_timing_if.gen                     tim,
  input  fb_cfg_t                      fb_cfg_i,

  output logic                         display_active_o,
  output logic                         end_of_frame_o,
  output logic                         hsync_o,
  output logic                         vsync_o,
  output logic                         pixel_valid_o,
  output logic                         in_fb_o,
  output logic                         half_sel_o,
  output logic                         rd_en_o,
  output logic [$clog2(LineWords):0]   rd_addr_o
);

  localparam int WordAddrWidth = $clog2(LineWords);

  logic [TimingWidth-1:0] h_counter;
  logic [TimingWidth-1:0] v_counter;
  logic [TimingWidth-1:0] h_last;
  logic [TimingWidth-1:0] v_last;
  logic [TimingWidth-1:0] v_last_disp;
  logic                   hsync;
  logic                   vsync;
  logic                   video_enable;
  logic                   end_of_frame_d;

  assign h_last      = tim.h_total - 1'b1;
  assign v_last      = tim.v_total - 1'b1;
  assign v_last_disp = tim.v_end_disp - 1'b1;

  // Counters sit at zero while the display is off
  always_ff @(posedge pxl_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      h_counter <= '0;
      v_counter <= '0;
    end else if (!display_en_i) begin
      h_counter <= '0;
      v_counter <= '0;
    end else if (h_counter == h_last) begin
      h_counter <= '0;
      v_counter <= (v_counter == v_last) ? '0 : v_counter + 1'b1;
    end else begin
      h_counter <= h_counter + 1'b1;
    end
  end

  always_comb begin
    hsync          = 1'b0;
    vsync          = 1'b0;
    video_enable   = 1'b0;
    end_of_frame_d = 1'b0;
    rd_en_o        = 1'b0;
    if (display_en_i) begin
      hsync = (h_counter >= tim.h_srt_sync && h_counter < tim.h_end_sync) ?
              !tim.hsync_pol : tim.hsync_pol;
      vsync = (v_counter >= tim.v_srt_sync && v_counter < tim.v_end_sync) ?
              !tim.vsync_pol : tim.vsync_pol;
      video_enable   = h_counter < tim.h_end_disp && v_counter < tim.v_end_disp;
      end_of_frame_d = h_counter == tim.h_end_disp && v_counter == v_last_disp;
      rd_en_o = h_counter < TimingWidth'(fb_cfg_i.width) &&
                v_counter < TimingWidth'(fb_cfg_i.height);
    end
  end

  // Line half from v bit 0, two pixels per word at depth 1
  assign rd_addr_o = {v_counter[0], fb_cfg_i.depth ? h_counter[WordAddrWidth:1]
                                                   : h_counter[WordAddrWidth-1:0]};

  ////////////////////////////////////////////////////////////
  // Outputs, one cycle behind the counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge pxl_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      display_active_o <= 1'b0;
      end_of_frame_o   <= 1'b0;
      hsync_o          <= 1'b0;
      vsync_o          <= 1'b0;
      pixel_valid_o    <= 1'b0;
      in_fb_o          <= 1'b0;
      half_sel_o       <= 1'b0;
    end else begin
      display_active_o <= display_en_i;
      end_of_frame_o   <= end_of_frame_d;
      hsync_o          <= hsync;
      vsync_o          <= vsync;
      pixel_valid_o    <= video_enable;
      in_fb_o          <= rd_en_o;
      half_sel_o       <= h_counter[0];
    end
  end

endmodule

//--- hw/dc_timing_if.sv
`timescale 1ns/1ps

// Video timing configuration, register block to timing generator
interface dc_timing_if import dc_pkg::*; ();

  logic [TimingWidth-1:0] h_total;
  logic [TimingWidth-1:0] h_end_disp;
  logic [TimingWidth-1:0] h_srt_sync;
  logic [TimingWidth-1:0] h_end_sync;
  logic [TimingWidth-1:0] v_total;
  logic [TimingWidth-1:0] v_end_disp;
  logic [TimingWidth-1:0] v_srt_sync;
  logic [TimingWidth-1:0] v_end_sync;
  logic                   hsync_pol;
  logic                   vsync_pol;

  modport regs (
    output h_total, h_end_disp, h_srt_sync, h_end_sync,
    output v_total, v_end_disp, v_srt_sync, v_end_sync,
    output hsync_pol, vsync_pol
  );

  modport gen (
    input h_total, h_end_disp, h_srt_sync, h_end_sync,
    input v_total, v_end_disp, v_srt_sync, v_end_sync,
    input hsync_pol, vsync_pol
  );

endinterface

//--- hw/display_controller.sv
`timescale 1ns/1ps

module display_controller import dc_pkg::*; #(
  parameter int LineWords = 1024
) (
  input  logic                       pxl_clk_i,
  input  logic                       rst_ni,

  // Register port
  input  logic                       ctrl_en_i,
  input  logic                       ctrl_we_i,
  input  logic [CtrlAddrWidth-1:0]   ctrl_addr_i,
  input  logic [31:0]                ctrl_wdata_i,
  output logic [31:0]                ctrl_rdata_o,

  // Line buffer fill, half bit on top
  input  logic                       lb_we_i,
  input  logic [$clog2(LineWords):0] lb_addr_i,
  input  logic [31:0]                lb_wdata_i,

  // Video out
  output logic [7:0]                 red_o,
  output logic [7:0]                 green_o,
  output logic [7:0]                 blue_o,
  output logic                       pixel_o,
  output logic                       hsync_o,
  output logic                       vsync_o
);

  ////////////////////////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////////////////////////

  dc_timing_if tim ();

  fb_cfg_t                    fb_cfg;
  logic                       display_en;
  logic                       display_active;
  logic                       end_of_frame;
  logic                       in_fb;
  logic                       half_sel;
  logic                       rd_en;
  logic [$clog2(LineWords):0] rd_addr;
  logic [31:0]                rd_data;

  dc_ctrl_regs u_ctrl_regs (
    .pxl_clk_i,
    .rst_ni,
    .ctrl_en_i,
    .ctrl_we_i,
    .ctrl_addr_i,
    .ctrl_wdata_i,
    .ctrl_rdata_o,
    .display_active_i (display_active),
    .end_of_frame_i   (end_of_frame),
    .display_en_o     (display_en),
    .fb_cfg_o         (fb_cfg),
    .tim              (tim.regs)
  );

  dc_timing_gen #(
    .LineWords (LineWords)
  ) u_timing_gen (
    .pxl_clk_i,
    .rst_ni,
    .display_en_i     (display_en),
    .tim              (tim.gen),
    .fb_cfg_i         (fb_cfg),
    .display_active_o (display_active),
    .end_of_frame_o   (end_of_frame),
    .hsync_o,
    .vsync_o,
    .pixel_valid_o    (pixel_o),
    .in_fb_o          (in_fb),
    .half_sel_o       (half_sel),
    .rd_en_o          (rd_en),
    .rd_addr_o        (rd_addr)
  );

  dc_line_buffer #(
    .LineWords (LineWords)
  ) u_line_buffer (
    .pxl_clk_i,
    .we_i      (lb_we_i),
    .waddr_i   (lb_addr_i),
    .wdata_i   (lb_wdata_i),
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  dc_pixel_fmt u_pixel_fmt (
    .pixel_valid_i (pixel_o),
    .in_fb_i       (in_fb),
    .half_sel_i    (half_sel),
    .fb_cfg_i      (fb_cfg),
    .rd_data_i     (rd_data),
    .red_o,
    .green_o,
    .blue_o
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the display controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
    -f build.f -o tb_sim; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi
echo "Simulation clean"
exit 0
